// File: pcie_queue_pkg.sv
`default_nettype none

package pcie_queue_pkg;

    // register and address widths
    localparam int DWORD_W       = 32;
    localparam int PCIE_ADDR_W   = 18;

    // page index starts at byte address bit 12
    localparam int PAGE_LSB      = 12;

    // byte offset inside one 512-bit line
    localparam int LINE_LSB      = 6;

    // tail, head, kmem low, kmem high
    localparam int REGS_PER_PAGE = 4;
    localparam int DEF_NB_QUEUES = 8;

    // lines below this index are register pages, the rest is ring buffer
    localparam int RB_BRAM_OFFSET = 512;

    typedef logic [DWORD_W-1:0]                 dword_t;
    typedef logic [2*DWORD_W-1:0]               kmem_addr_t;
    typedef logic [PCIE_ADDR_W-1:0]             pcie_addr_t;
    typedef logic [8*(1<<LINE_LSB)-1:0]         line_t;
    typedef logic [(1<<LINE_LSB)-1:0]           byte_en_t;

    // dword 0 sits in the low bits
    typedef logic [REGS_PER_PAGE*DWORD_W-1:0]   page_t;

    // line index into the ring buffer
    typedef logic [PCIE_ADDR_W-LINE_LSB-1:0]    frb_addr_t;

    // programmed number of active queues
    typedef logic [4:0]                         qcount_t;

    typedef enum logic [1:0] {
        IDLE,
        BRAM_DELAY_1,
        BRAM_DELAY_2,
        SWITCH_QUEUE
    } switch_state_t;

endpackage

`default_nettype wire

// File: queue_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface queue_ctrl_if
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
);

    // active queue and the tail store strobe from the FSM
    logic [QW-1:0] cur_queue;
    logic          tail_we;
    dword_t        tail_data;

    // live page contents of cur_queue
    dword_t        sel_tail;
    dword_t        sel_head;
    kmem_addr_t    sel_kmem_addr;

    modport fsm (
        output cur_queue, tail_we, tail_data,
        input  sel_tail, sel_head, sel_kmem_addr
    );

    modport regs (
        input  cur_queue, tail_we, tail_data,
        output sel_tail, sel_head, sel_kmem_addr
    );

endinterface

`default_nettype wire

// File: queue_rr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module queue_rr_counter
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
) (
    input  logic          pcie_clk,
    input  logic          pcie_reset_n,
    input  qcount_t       nb_queues,
    input  logic          advance,
    output logic [QW-1:0] next_queue
);

    logic last_queue;

    // wrap at the programmed count, and never beyond the built queues
    assign last_queue = (int'(next_queue) + 1 >= int'(nb_queues)) ||
                        (int'(next_queue) + 1 >= NB_QUEUES);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            // queue 0 is active out of reset, so queue 1 is served next
            next_queue <= (nb_queues > qcount_t'(1) && NB_QUEUES > 1) ? QW'(1) : '0;
        end else if (advance) begin
            if (last_queue) begin
                next_queue <= '0;
            end else begin
                next_queue <= next_queue + QW'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: queue_switch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module queue_switch_fsm
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
) (
    input  logic         pcie_clk,
    input  logic         pcie_reset_n,
    input  qcount_t      nb_queues,
    input  logic         dma_done,
    input  dword_t       new_tail,
    queue_ctrl_if.fsm    ctrl
);

    switch_state_t state;
    logic          accept;
    logic          advance;
    logic [QW-1:0] next_queue;

    queue_rr_counter #(
        .NB_QUEUES (NB_QUEUES)
    ) u_rr_counter (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .nb_queues    (nb_queues),
        .advance      (advance),
        .next_queue   (next_queue)
    );

    // completion only counts in IDLE with no tail store in flight
    assign accept  = (state == IDLE) && dma_done && !ctrl.tail_we;
    assign advance = (state == SWITCH_QUEUE);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state          <= IDLE;
            ctrl.cur_queue <= '0;
            ctrl.tail_we   <= 1'b0;
        end else begin
            ctrl.tail_we <= 1'b0;
            case (state)
                IDLE: begin
                    // store the tail first, then give the table read its two cycles
                    if (ctrl.tail_we) begin
                        state <= BRAM_DELAY_1;
                    end else if (accept) begin
                        ctrl.tail_we <= 1'b1;
                    end
                end
                BRAM_DELAY_1: begin
                    state <= BRAM_DELAY_2;
                end
                BRAM_DELAY_2: begin
                    state <= SWITCH_QUEUE;
                end
                SWITCH_QUEUE: begin
                    // counter steps on this same edge
                    ctrl.cur_queue <= next_queue;
                    state          <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // new tail held for the store cycle
    always_ff @(posedge pcie_clk) begin
        if (accept) begin
            ctrl.tail_data <= new_tail;
        end
    end

endmodule

`default_nettype wire

// File: queue_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module queue_reg_file
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
) (
    input  logic          pcie_clk,
    input  logic          pcie_reset_n,
    input  pcie_addr_t    pcie_address,
    input  logic          pcie_write,
    input  line_t         pcie_writedata,
    input  byte_en_t      pcie_byteenable,
    input  logic [QW-1:0] rd_page,
    output page_t         rd_words,
    output logic [QW-1:0] active_queue,
    output dword_t        active_tail,
    output dword_t        active_head,
    output kmem_addr_t    active_kmem_addr,
    queue_ctrl_if.regs    ctrl
);

    localparam int BE_PER_DWORD = DWORD_W / 8;

    // one page per queue: tail, head, kmem low, kmem high
    dword_t                           regs [NB_QUEUES][REGS_PER_PAGE];
    logic [PCIE_ADDR_W-PAGE_LSB-1:0]  wr_page_num;
    logic [QW-1:0]                    wr_page;
    logic                             wr_hit;

    assign wr_page_num = pcie_address[PCIE_ADDR_W-1:PAGE_LSB];
    assign wr_page     = wr_page_num[QW-1:0];

    // only register-region writes to an existing page
    assign wr_hit = pcie_write
        && (int'(pcie_address[PCIE_ADDR_W-1:LINE_LSB]) < RB_BRAM_OFFSET)
        && (int'(wr_page_num) < NB_QUEUES);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int q = 0; q < NB_QUEUES; q++) begin
                for (int j = 0; j < REGS_PER_PAGE; j++) begin
                    regs[q][j] <= '0;
                end
            end
        end else begin
            if (ctrl.tail_we) begin
                regs[ctrl.cur_queue][0] <= ctrl.tail_data;
            end
            if (wr_hit) begin
                // dword 0 is the tail and belongs to the DMA side
                for (int j = 1; j < REGS_PER_PAGE; j++) begin
                    if (&pcie_byteenable[j*BE_PER_DWORD +: BE_PER_DWORD]) begin
                        regs[wr_page][j] <= pcie_writedata[j*DWORD_W +: DWORD_W];
                    end
                end
            end
        end
    end

    assign ctrl.sel_tail      = regs[ctrl.cur_queue][0];
    assign ctrl.sel_head      = regs[ctrl.cur_queue][1];
    assign ctrl.sel_kmem_addr = {regs[ctrl.cur_queue][3], regs[ctrl.cur_queue][2]};

    // page lookup for the PIO read path
    always_comb begin
        rd_words = '0;
        if (int'(rd_page) < NB_QUEUES) begin
            for (int j = 0; j < REGS_PER_PAGE; j++) begin
                rd_words[j*DWORD_W +: DWORD_W] = regs[rd_page][j];
            end
        end
    end

    // registered view of the active queue for the DMA engine
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            active_queue     <= '0;
            active_tail      <= '0;
            active_head      <= '0;
            active_kmem_addr <= '0;
        end else begin
            active_queue     <= ctrl.cur_queue;
            active_tail      <= ctrl.sel_tail;
            active_head      <= ctrl.sel_head;
            active_kmem_addr <= ctrl.sel_kmem_addr;
        end
    end

endmodule

`default_nettype wire

// File: pio_read_path.sv
`timescale 1ns/1ps
`default_nettype none

module pio_read_path
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
) (
    input  logic          pcie_clk,
    input  logic          pcie_reset_n,
    input  pcie_addr_t    pcie_address,
    input  logic          pcie_read,
    input  page_t         rd_words,
    input  line_t         frb_readdata,
    input  logic          frb_readvalid,
    output logic [QW-1:0] rd_page,
    output logic          frb_read,
    output frb_addr_t     frb_address,
    output line_t         pcie_readdata,
    output logic          pcie_readdatavalid
);

    frb_addr_t line_idx;
    logic      reg_region;
    logic      region_r1;
    logic      region_r2;
    logic      read_r1;
    logic      read_r2;
    page_t     page_data;

    assign line_idx   = pcie_address[PCIE_ADDR_W-1:LINE_LSB];
    assign reg_region = line_idx < frb_addr_t'(RB_BRAM_OFFSET);
    assign rd_page    = pcie_address[PAGE_LSB +: QW];

    // reads above the register pages go straight to the ring buffer
    assign frb_read    = pcie_read & ~reg_region;
    assign frb_address = line_idx - frb_addr_t'(RB_BRAM_OFFSET);

    // two-cycle register read pipeline
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            region_r1 <= 1'b0;
            region_r2 <= 1'b0;
            read_r1   <= 1'b0;
            read_r2   <= 1'b0;
        end else begin
            region_r1 <= reg_region;
            region_r2 <= region_r1;
            read_r1   <= pcie_read;
            read_r2   <= read_r1;
        end
    end

    // page captured one cycle after the read strobe
    always_ff @(posedge pcie_clk) begin
        page_data <= rd_words;
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pcie_readdatavalid <= 1'b0;
        end else if (read_r2 && region_r2) begin
            pcie_readdatavalid <= 1'b1;
        end else begin
            pcie_readdatavalid <= frb_readvalid;
        end
    end

    // page in the low bits, zero above
    always_ff @(posedge pcie_clk) begin
        if (read_r2 && region_r2) begin
            pcie_readdata <= line_t'(page_data);
        end else begin
            pcie_readdata <= frb_readdata;
        end
    end

endmodule

`default_nettype wire

// File: pcie_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_queue_top
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
) (
    input  logic          pcie_clk,
    input  logic          pcie_reset_n,
    input  qcount_t       nb_queues,

    // PIO port
    input  pcie_addr_t    pcie_address,
    input  logic          pcie_write,
    input  logic          pcie_read,
    input  line_t         pcie_writedata,
    input  byte_en_t      pcie_byteenable,
    output line_t         pcie_readdata,
    output logic          pcie_readdatavalid,

    // DMA engine side
    input  logic          dma_done,
    input  dword_t        new_tail,
    output logic [QW-1:0] active_queue,
    output dword_t        active_tail,
    output dword_t        active_head,
    output kmem_addr_t    active_kmem_addr,

    // ring-buffer read port
    output logic          frb_read,
    output frb_addr_t     frb_address,
    input  line_t         frb_readdata,
    input  logic          frb_readvalid
);

    logic [QW-1:0] rd_page;
    page_t         rd_words;

    queue_ctrl_if #(
        .NB_QUEUES (NB_QUEUES)
    ) u_ctrl_if ();

    queue_switch_fsm #(
        .NB_QUEUES (NB_QUEUES)
    ) u_switch_fsm (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .nb_queues    (nb_queues),
        .dma_done     (dma_done),
        .new_tail     (new_tail),
        .ctrl         (u_ctrl_if)
    );

    queue_reg_file #(
        .NB_QUEUES (NB_QUEUES)
    ) u_reg_file (
        .pcie_clk         (pcie_clk),
        .pcie_reset_n     (pcie_reset_n),
        .pcie_address     (pcie_address),
        .pcie_write       (pcie_write),
        .pcie_writedata   (pcie_writedata),
        .pcie_byteenable  (pcie_byteenable),
        .rd_page          (rd_page),
        .rd_words         (rd_words),
        .active_queue     (active_queue),
        .active_tail      (active_tail),
        .active_head      (active_head),
        .active_kmem_addr (active_kmem_addr),
        .ctrl             (u_ctrl_if)
    );

    pio_read_path #(
        .NB_QUEUES (NB_QUEUES)
    ) u_read_path (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_address       (pcie_address),
        .pcie_read          (pcie_read),
        .rd_words           (rd_words),
        .frb_readdata       (frb_readdata),
        .frb_readvalid      (frb_readvalid),
        .rd_page            (rd_page),
        .frb_read           (frb_read),
        .frb_address        (frb_address),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid)
    );

endmodule

`default_nettype wire

// File: pcie_queue_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_queue_checker
    import pcie_queue_pkg::*;
#(
    parameter int  NB_QUEUES = DEF_NB_QUEUES,
    localparam int QW        = (NB_QUEUES > 1) ? $clog2(NB_QUEUES) : 1
) (
    input logic          pcie_clk,
    input logic          pcie_reset_n,
    input qcount_t       nb_queues,
    input pcie_addr_t    pcie_address,
    input logic          pcie_read,
    input logic          pcie_readdatavalid,
    input logic [QW-1:0] active_queue
);

    logic reg_read;

    assign reg_read = pcie_read
        && (int'(pcie_address[PCIE_ADDR_W-1:LINE_LSB]) < RB_BRAM_OFFSET);

    // valid is set at the second edge after the strobe and sampled at the next one
    a_reg_read_latency: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
            reg_read |-> ##3 pcie_readdatavalid
    ) else $error("register read without read data valid two cycles later");

    a_active_in_range: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
            int'(active_queue) < int'(nb_queues)
    ) else $error("active_queue at or above nb_queues");

    // valid cleared one edge into reset
    a_no_valid_in_reset: assert property (
        @(posedge pcie_clk)
            !pcie_reset_n |=> !pcie_readdatavalid
    ) else $error("read data valid high during reset");

endmodule

bind pcie_queue_top pcie_queue_checker #(
    .NB_QUEUES (NB_QUEUES)
) u_checker (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .nb_queues          (nb_queues),
    .pcie_address       (pcie_address),
    .pcie_read          (pcie_read),
    .pcie_readdatavalid (pcie_readdatavalid),
    .active_queue       (active_queue)
);

`default_nettype wire

// File: tb_pcie_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_queue
    import pcie_queue_pkg::*;
();

    localparam int NB_QUEUES = 8;
    localparam int QW        = 3;
    localparam int MAX_ROWS  = 40;
    localparam int TIMEOUT   = 50;
    localparam int OP_WRITE  = 0;
    localparam int OP_READ   = 1;
    localparam int OP_DMA    = 2;
    localparam int OP_CHECK  = 3;

    logic          pcie_clk;
    logic          pcie_reset_n;
    qcount_t       nb_queues;
    pcie_addr_t    pcie_address;
    logic          pcie_write;
    logic          pcie_read;
    line_t         pcie_writedata;
    byte_en_t      pcie_byteenable;
    line_t         pcie_readdata;
    logic          pcie_readdatavalid;
    logic          dma_done;
    dword_t        new_tail;
    logic [QW-1:0] active_queue;
    dword_t        active_tail;
    dword_t        active_head;
    kmem_addr_t    active_kmem_addr;
    logic          frb_read;
    frb_addr_t     frb_address;
    line_t         frb_readdata = '0;
    logic          frb_readvalid = 1'b0;

    // one row per operation, with its expected result
    int         row_op   [MAX_ROWS];
    pcie_addr_t row_addr [MAX_ROWS];
    line_t      row_data [MAX_ROWS];
    byte_en_t   row_be   [MAX_ROWS];
    line_t      row_exp  [MAX_ROWS];
    string      op_names [4] = '{"write", "read", "dma_done", "check-active"};
    int         nb_rows;

    // expected register pages and queue order
    dword_t     model_regs [NB_QUEUES][REGS_PER_PAGE];
    int         model_cur;
    int         model_next;

    int         seed;
    int         errors;
    int         row_errors;
    int         passed;
    int         failed;

    pcie_queue_top #(
        .NB_QUEUES (NB_QUEUES)
    ) u_dut (
        .*
    );

    initial begin
        pcie_clk = 1'b0;
        forever #20 pcie_clk = ~pcie_clk;
    end

    // ring buffer answers one cycle later, its line address in every dword
    always @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            frb_readvalid <= 1'b0;
            frb_readdata  <= '0;
        end else begin
            frb_readvalid <= frb_read;
            if (frb_read) begin
                frb_readdata <= {16{32'(frb_address)}};
            end
        end
    end

    task automatic compare(input string name, input line_t got, input line_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %0h, expected %0h", name, got, expected);
            row_errors++;
        end
    endtask

    task automatic table_row(input int op, input pcie_addr_t addr, input line_t data,
                             input byte_en_t be);
        int    q;
        int    line_idx;
        line_t expected;
        q        = int'(addr[PCIE_ADDR_W-1:PAGE_LSB]);
        line_idx = int'(addr[PCIE_ADDR_W-1:LINE_LSB]);
        expected = '0;
        case (op)
            OP_WRITE: begin
                // tail dword stays with the DMA side
                for (int j = 1; j < REGS_PER_PAGE; j++) begin
                    if (line_idx < RB_BRAM_OFFSET && &be[j*4 +: 4]) begin
                        model_regs[q][j] = data[j*32 +: 32];
                    end
                end
            end
            OP_READ: begin
                if (line_idx >= RB_BRAM_OFFSET) begin
                    expected = {16{32'(line_idx - RB_BRAM_OFFSET)}};
                end else begin
                    for (int j = 0; j < REGS_PER_PAGE; j++) begin
                        expected[j*32 +: 32] = model_regs[q][j];
                    end
                end
            end
            OP_DMA: begin
                // tail lands in the active queue, then round robin over nb_queues
                model_regs[model_cur][0] = data[31:0];
                model_cur  = model_next;
                model_next = (model_next + 1 >= int'(nb_queues)) ? 0 : model_next + 1;
                expected   = line_t'(model_cur);
            end
            default: begin
                expected[31:0]   = 32'(model_cur);
                expected[63:32]  = model_regs[model_cur][0];
                expected[95:64]  = model_regs[model_cur][1];
                expected[159:96] = {model_regs[model_cur][3], model_regs[model_cur][2]};
            end
        endcase
        row_op[nb_rows]   = op;
        row_addr[nb_rows] = addr;
        row_data[nb_rows] = data;
        row_be[nb_rows]   = be;
        row_exp[nb_rows]  = expected;
        nb_rows++;
    endtask

    task automatic apply_write(input int i);
        @(posedge pcie_clk);
        pcie_address    <= row_addr[i];
        pcie_writedata  <= row_data[i];
        pcie_byteenable <= row_be[i];
        pcie_write      <= 1'b1;
        @(posedge pcie_clk);
        pcie_write      <= 1'b0;
    endtask

    task automatic issue_read(input int i);
        int lat;
        int line_idx;
        bit seen;
        bit ring;
        line_idx = int'(row_addr[i][PCIE_ADDR_W-1:LINE_LSB]);
        ring     = (line_idx >= RB_BRAM_OFFSET);
        @(posedge pcie_clk);
        pcie_address <= row_addr[i];
        pcie_read    <= 1'b1;
        // ring-buffer strobe and line address follow the read combinationally
        @(negedge pcie_clk);
        compare("frb_read", line_t'(frb_read), line_t'(ring));
        if (ring) begin
            compare("frb_address", line_t'(frb_address), line_t'(line_idx - RB_BRAM_OFFSET));
        end
        @(posedge pcie_clk);
        pcie_read    <= 1'b0;
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < TIMEOUT) begin
            @(posedge pcie_clk);
            @(negedge pcie_clk);
            lat++;
            seen = pcie_readdatavalid;
        end
        if (!seen) begin
            $display("read of address %h never returned read data valid", row_addr[i]);
            row_errors++;
        end else begin
            compare("pcie_readdata", pcie_readdata, row_exp[i]);
            if (!ring) begin
                compare("read latency", line_t'(lat), line_t'(2));
            end
            // a single valid pulse per read
            for (int k = 0; k < 3; k++) begin
                @(negedge pcie_clk);
                compare("pcie_readdatavalid", line_t'(pcie_readdatavalid), '0);
            end
        end
    endtask

    task automatic complete_dma(input int i);
        int            lat;
        logic [QW-1:0] old_queue;
        @(posedge pcie_clk);
        dma_done <= 1'b1;
        new_tail <= row_data[i][31:0];
        @(posedge pcie_clk);
        dma_done <= 1'b0;
        @(negedge pcie_clk);
        old_queue = active_queue;
        lat       = 0;
        while (active_queue == old_queue && lat < TIMEOUT) begin
            @(posedge pcie_clk);
            @(negedge pcie_clk);
            lat++;
        end
        if (active_queue == old_queue) begin
            $display("active_queue did not switch after dma_done");
            row_errors++;
        end else begin
            compare("active_queue", line_t'(active_queue), row_exp[i]);
            compare("switch latency", line_t'(lat), line_t'(5));
        end
    endtask

    task automatic inspect_active(input int i);
        @(negedge pcie_clk);
        compare("active_queue", line_t'(active_queue), line_t'(row_exp[i][31:0]));
        compare("active_tail", line_t'(active_tail), line_t'(row_exp[i][63:32]));
        compare("active_head", line_t'(active_head), line_t'(row_exp[i][95:64]));
        compare("active_kmem_addr", line_t'(active_kmem_addr), line_t'(row_exp[i][159:96]));
    endtask

    initial begin
        line_t wdata;
        seed = 10266;
        errors = 0;
        passed = 0;
        failed = 0;
        nb_rows = 0;
        model_cur = 0;
        model_next = 1;
        for (int q = 0; q < NB_QUEUES; q++) begin
            for (int j = 0; j < REGS_PER_PAGE; j++) begin
                model_regs[q][j] = '0;
            end
        end
        pcie_reset_n    = 1'b0;
        nb_queues       = 5'd3;
        pcie_address    = '0;
        pcie_write      = 1'b0;
        pcie_read       = 1'b0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        dma_done        = 1'b0;
        new_tail        = '0;

        // every page is zero out of reset
        for (int q = 0; q < NB_QUEUES; q++) begin
            table_row(OP_READ, pcie_addr_t'(q << PAGE_LSB), '0, '0);
        end
        table_row(OP_CHECK, '0, '0, '0);
        for (int q = 0; q < 3; q++) begin
            wdata = '0;
            for (int j = 0; j < REGS_PER_PAGE; j++) begin
                wdata[j*32 +: 32] = $random(seed);
            end
            table_row(OP_WRITE, pcie_addr_t'(q << PAGE_LSB), wdata, byte_en_t'(16'hffff));
        end
        // tail dword and a partial head enable are both dropped
        table_row(OP_WRITE, 18'h00000, {16{32'hdeadbeef}}, byte_en_t'(16'h000f));
        table_row(OP_WRITE, 18'h01000, {16{32'hdeadbeef}}, byte_en_t'(16'h0070));
        for (int q = 0; q < 3; q++) begin
            table_row(OP_READ, pcie_addr_t'(q << PAGE_LSB), '0, '0);
        end
        table_row(OP_READ, 18'h08140, '0, '0);
        table_row(OP_READ, 18'h3ffc0, '0, '0);
        // four completions walk the queues 1, 2, 0, 1
        for (int k = 0; k < 4; k++) begin
            table_row(OP_DMA, '0, line_t'(32'($random(seed))), '0);
            table_row(OP_CHECK, '0, '0, '0);
            if (k == 0) begin
                table_row(OP_READ, '0, '0, '0);
            end
        end

        repeat (10) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
        for (int i = 0; i < nb_rows; i++) begin
            row_errors = 0;
            case (row_op[i])
                OP_WRITE: apply_write(i);
                OP_READ:  issue_read(i);
                OP_DMA:   complete_dma(i);
                default:  inspect_active(i);
            endcase
            if (row_errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
            errors += row_errors;
            $display("test %0d %s: %0d mismatches", i, op_names[row_op[i]], row_errors);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 nb_rows, passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
pcie_queue_pkg.sv
queue_ctrl_if.sv
queue_rr_counter.sv
queue_switch_fsm.sv
queue_reg_file.sv
pio_read_path.sv
pcie_queue_top.sv
pcie_queue_checker.sv
tb_pcie_queue.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_pcie_queue \
		-f list.f -Mdir obj_dir -o sim_pcie_queue
	./obj_dir/sim_pcie_queue | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
